//--- include/uart_consts.svh
// Build-time constants for the UART line subsystem; include wherever a default or limit is needed
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// Clock cycles per serial bit, 25 MHz clock at 115200 baud
`define UART_CLKS_PER_BIT 217

// Receive FIFO entries, keep this a power of two
`define UART_FIFO_DEPTH 8

// Longest line the assembler counts before flagging it
`define LINE_MAX_LEN 32

// Line feed ends a line
`define LINE_TERM 8'h0A

`endif

//--- src/uart_pkg.sv
// Serial-side types shared by the receiver, the FIFO and everything that reads received bytes
`default_nettype none

package uart_pkg;

  // One data byte off the wire
  typedef logic [7:0] uart_byte_t;

  // Index of a data bit inside a frame, LSB first
  typedef logic [2:0] uart_bit_idx_t;

  // Receiver FSM states
  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } uart_rx_state_t;

  // A received byte together with its stop-bit check
  typedef struct packed {
    uart_byte_t data;
    logic       framing_err;
  } rx_byte_t;

endpackage

`default_nettype wire

//--- src/line_pkg.sv
// Line-side types for the assembler and anything that consumes line summaries
`default_nettype none

`include "uart_consts.svh"

package line_pkg;

  import uart_pkg::*;

  // Line length, wide enough to hold LINE_MAX_LEN itself
  typedef logic [$clog2(`LINE_MAX_LEN + 1)-1:0] line_len_t;

  // Summary reported with each line_done
  typedef struct packed {
    line_len_t  length;
    uart_byte_t checksum;
    logic       error;
  } line_info_t;

  typedef enum logic {
    COLLECT,
    OVERLONG
  } line_state_t;

endpackage

`default_nettype wire

//--- src/uart_rx.sv
// 8N1 serial receiver with mid-bit sampling; emits one strobe per frame with a framing flag
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module uart_rx
  import uart_pkg::*;
#(
  parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
  input  wire      clk,
  input  wire      reset,
  input  wire      serial_in,
  output logic     byte_valid,
  output rx_byte_t rx_data
);

  // One extra count value marks "stop bit was low, wait for idle line"
  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

  localparam logic [CNT_W-1:0] HALF_BIT  = CNT_W'((CLKS_PER_BIT - 1) / 2);
  localparam logic [CNT_W-1:0] LAST_CNT  = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] WAIT_HIGH = CNT_W'(CLKS_PER_BIT);

  localparam uart_bit_idx_t LAST_BIT = 3'd7;

  uart_rx_state_t   state;
  logic [CNT_W-1:0] counter;
  uart_bit_idx_t    bit_idx;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= IDLE;
      counter    <= '0;
      bit_idx    <= '0;
      byte_valid <= 1'b0;
      rx_data    <= '0;
    end else begin
      byte_valid <= 1'b0;

      case (state)
        IDLE: begin
          counter <= '0;
          bit_idx <= '0;
          // Falling edge of the start bit
          if (!serial_in) begin
            state <= START;
          end
        end

        START: begin
          if (counter == HALF_BIT) begin
            counter <= '0;
            // Line back high at mid-bit means it was a glitch
            if (serial_in) begin
              state <= IDLE;
            end else begin
              state <= DATA;
            end
          end else begin
            counter <= counter + 1'b1;
          end
        end

        DATA: begin
          if (counter == LAST_CNT) begin
            counter               <= '0;
            rx_data.data[bit_idx] <= serial_in;
            bit_idx               <= bit_idx + 1'b1;
            if (bit_idx == LAST_BIT) begin
              state <= STOP;
            end
          end else begin
            counter <= counter + 1'b1;
          end
        end

        STOP: begin
          if (counter == WAIT_HIGH) begin
            // Bad stop bit already reported, just wait out the low line
            if (serial_in) begin
              state <= IDLE;
            end
          end else if (counter == LAST_CNT) begin
            rx_data.framing_err <= ~serial_in;
            byte_valid          <= 1'b1;
            if (serial_in) begin
              state <= IDLE;
            end else begin
              counter <= WAIT_HIGH;
            end
          end else begin
            counter <= counter + 1'b1;
          end
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/rx_fifo.sv
// Show-ahead byte FIFO between receiver and assembler; drops pushes when full and flags it
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module rx_fifo
  import uart_pkg::*;
#(
  parameter int DEPTH = `UART_FIFO_DEPTH
) (
  input  wire      clk,
  input  wire      reset,
  input  wire      push,
  input  wire      rx_byte_t push_data,
  input  wire      pop,
  output rx_byte_t head,
  output logic     empty,
  output logic     overflow
);

  localparam int AW = $clog2(DEPTH);

  rx_byte_t    mem [DEPTH];
  // Extra MSB tells a full buffer from an empty one
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;
  logic        full;
  logic        do_push;
  logic        do_pop;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  assign do_pop  = pop && !empty;
  // A pop in the same cycle frees the slot being written
  assign do_push = push && (!full || do_pop);

  assign head = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr[AW-1:0]] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Sticky until reset
      if (push && !do_push) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/line_assembler.sv
// Drains the receive FIFO and reports length, XOR checksum and error for each LF-terminated line
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module line_assembler
  import uart_pkg::*, line_pkg::*;
(
  input  wire        clk,
  input  wire        reset,
  input  wire        rx_byte_t head,
  input  wire        empty,
  input  wire        pause,
  output logic       pop,
  output logic       line_done,
  output line_info_t line_info
);

  localparam line_len_t MAX_LEN = line_len_t'(`LINE_MAX_LEN);

  line_state_t state;
  line_len_t   len;
  uart_byte_t  csum;
  logic        err;
  logic        is_term;

  // Every available byte is taken unless paused
  assign pop     = !empty && !pause;
  assign is_term = (head.data == `LINE_TERM);

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= COLLECT;
      len       <= '0;
      csum      <= '0;
      err       <= 1'b0;
      line_done <= 1'b0;
      line_info <= '0;
    end else begin
      line_done <= 1'b0;

      if (pop) begin
        if (is_term) begin
          line_done <= 1'b1;
          line_info <= '{length: len, checksum: csum, error: err | head.framing_err};
          state     <= COLLECT;
          len       <= '0;
          csum      <= '0;
          err       <= 1'b0;
        end else if (state == OVERLONG) begin
          // Length and checksum frozen until the terminator
          err <= 1'b1;
        end else if (len == MAX_LEN) begin
          state <= OVERLONG;
          err   <= 1'b1;
        end else begin
          len  <= len + 1'b1;
          csum <= csum ^ head.data;
          // bad stop bit still counts the byte
          err  <= err | head.framing_err;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- src/uart_line_top.sv
// Top of the serial line subsystem; receiver feeds the FIFO, assembler drains it into line summaries
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module uart_line_top
  import uart_pkg::*, line_pkg::*;
#(
  parameter int CLKS_PER_BIT = `UART_CLKS_PER_BIT
) (
  input  wire        clk,
  input  wire        reset,
  input  wire        serial_in,
  input  wire        pause,
  output logic       line_done,
  output line_info_t line_info,
  output logic       overflow
);

  logic     byte_valid;
  rx_byte_t rx_data;
  rx_byte_t head;
  logic     empty;
  logic     pop;

  uart_rx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) u_rx (
    .clk       (clk),
    .reset     (reset),
    .serial_in (serial_in),
    .byte_valid(byte_valid),
    .rx_data   (rx_data)
  );

  rx_fifo #(
    .DEPTH(`UART_FIFO_DEPTH)
  ) u_fifo (
    .clk      (clk),
    .reset    (reset),
    .push     (byte_valid),
    .push_data(rx_data),
    .pop      (pop),
    .head     (head),
    .empty    (empty),
    .overflow (overflow)
  );

  line_assembler u_asm (
    .clk      (clk),
    .reset    (reset),
    .head     (head),
    .empty    (empty),
    .pause    (pause),
    .pop      (pop),
    .line_done(line_done),
    .line_info(line_info)
  );

endmodule

`default_nettype wire

//--- bench/uart_line_tb.sv
// Directed testbench that drives uart_line_top and checks its line summaries, built from sim.f
`timescale 1ns/1ps
`default_nettype none

`include "uart_consts.svh"

module uart_line_tb
  import uart_pkg::*, line_pkg::*;
();

  localparam int BIT_CLKS     = 16;
  localparam int LINE_TIMEOUT = 2000;

  logic       clk;
  logic       reset;
  logic       serial_in;
  logic       pause;
  logic       line_done;
  line_info_t line_info;
  logic       overflow;

  // Expected summaries from the model and summaries seen on the DUT
  line_info_t  exp_q[$];
  line_info_t  got_q[$];
  int          model_len;
  uart_byte_t  model_csum;
  logic        model_err;
  int          errors;
  int          tests_run;
  int          tests_failed;
  int unsigned seed_dummy;

  uart_line_top #(
    .CLKS_PER_BIT(BIT_CLKS)
  ) uut (
    .clk      (clk),
    .reset    (reset),
    .serial_in(serial_in),
    .pause    (pause),
    .line_done(line_done),
    .line_info(line_info),
    .overflow (overflow)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // Collect each summary while line_done is high
  always @(negedge clk) begin
    if (!reset && line_done) begin
      got_q.push_back(line_info);
    end
  end

  task automatic check_info(input string what, input line_info_t got, input line_info_t exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got len %0d csum %h err %b, expected len %0d csum %h err %b",
               $time, what, got.length, got.checksum, got.error,
               exp.length, exp.checksum, exp.error);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Reference line model fed with every byte that reaches the assembler
  function automatic void model_byte(input uart_byte_t data, input logic ferr);
    line_info_t info;
    if (data == `LINE_TERM) begin
      info.length   = line_len_t'(model_len);
      info.checksum = model_csum;
      info.error    = model_err | ferr;
      exp_q.push_back(info);
      model_len  = 0;
      model_csum = '0;
      model_err  = 1'b0;
    end else begin
      model_err = model_err | ferr;
      if (model_len < `LINE_MAX_LEN) begin
        model_len++;
        model_csum = model_csum ^ data;
      end else begin
        // Past the limit a byte only marks the line bad
        model_err = 1'b1;
      end
    end
  endfunction

  function automatic uart_byte_t random_byte();
    uart_byte_t b;
    b = uart_byte_t'($urandom);
    // An LF here would end the line early
    if (b == `LINE_TERM) begin
      b = 8'h5A;
    end
    return b;
  endfunction

  task automatic drive_bit(input logic level);
    serial_in = level;
    repeat (BIT_CLKS) @(negedge clk);
  endtask

  // One 8N1 frame sent LSB first from a falling edge
  task automatic send_byte(input uart_byte_t data, input logic bad_stop);
    int i;
    drive_bit(1'b0);
    for (i = 0; i < 8; i++) begin
      drive_bit(data[i]);
    end
    drive_bit(!bad_stop);
    serial_in = 1'b1;
    repeat (2) @(negedge clk);
  endtask

  task automatic send_tracked(input uart_byte_t data, input logic bad_stop);
    model_byte(data, bad_stop);
    send_byte(data, bad_stop);
  endtask

  task automatic expect_line(input string what);
    int         cycles;
    line_info_t got;
    line_info_t exp;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (got_q.size() == 0 && cycles < LINE_TIMEOUT);
    if (got_q.size() == 0) begin
      errors++;
      $display("Error at %0t: line_done never came for %s within %0d cycles",
               $time, what, LINE_TIMEOUT);
      if (exp_q.size() > 0) begin
        exp = exp_q.pop_front();
      end
    end else if (exp_q.size() == 0) begin
      errors++;
      got = got_q.pop_front();
      $display("Error at %0t: line_done came for %s with no line expected", $time, what);
    end else begin
      got = got_q.pop_front();
      exp = exp_q.pop_front();
      check_info(what, got, exp);
    end
    @(negedge clk);
  endtask

  task automatic expect_no_line(input string what);
    if (got_q.size() != 0) begin
      errors++;
      $display("Error at %0t: line_done came too early during %s", $time, what);
      got_q.delete();
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic test_reset_state();
    int   start;
    logic seen_done;
    logic seen_ovf;
    start     = errors;
    seen_done = 1'b0;
    seen_ovf  = 1'b0;
    serial_in = 1'b1;
    repeat (200) begin
      @(negedge clk);
      seen_done = seen_done | line_done;
      seen_ovf  = seen_ovf | overflow;
    end
    check_flag("line_done after reset", seen_done, 1'b0);
    check_flag("overflow after reset", seen_ovf, 1'b0);
    check_info("line_info after reset", line_info, '0);
    report_test("reset state", start);
  endtask

  task automatic test_clean_lines();
    int start;
    int n;
    int i;
    int k;
    start = errors;
    send_tracked(8'h41, 1'b0);
    send_tracked(8'h42, 1'b0);
    send_tracked(`LINE_TERM, 1'b0);
    expect_line("fixed line AB");
    for (k = 0; k < 3; k++) begin
      n = $urandom_range(10, 0);
      for (i = 0; i < n; i++) begin
        send_tracked(random_byte(), 1'b0);
      end
      send_tracked(`LINE_TERM, 1'b0);
      expect_line("random line");
    end
    report_test("clean lines", start);
  endtask

  task automatic test_framing_error();
    int start;
    start = errors;
    send_tracked(8'h78, 1'b0);
    send_tracked(8'h79, 1'b1);
    send_tracked(8'h7A, 1'b0);
    send_tracked(`LINE_TERM, 1'b0);
    expect_line("line with bad stop bit");
    send_tracked(8'h6F, 1'b0);
    send_tracked(8'h6B, 1'b0);
    send_tracked(`LINE_TERM, 1'b0);
    expect_line("clean line after bad stop bit");
    report_test("framing error", start);
  endtask

  task automatic test_glitch();
    int start;
    start     = errors;
    serial_in = 1'b0;
    repeat (4) @(negedge clk);
    serial_in = 1'b1;
    repeat (40) @(negedge clk);
    expect_no_line("start glitch");
    send_tracked(8'h68, 1'b0);
    send_tracked(8'h69, 1'b0);
    send_tracked(`LINE_TERM, 1'b0);
    expect_line("line after glitch");
    report_test("start glitch", start);
  endtask

  task automatic test_overlong();
    int start;
    int i;
    start = errors;
    for (i = 0; i < 40; i++) begin
      send_tracked(random_byte(), 1'b0);
    end
    send_tracked(`LINE_TERM, 1'b0);
    expect_line("40 byte line");
    report_test("overlong line", start);
  endtask

  task automatic test_pause();
    int         start;
    int         i;
    uart_byte_t b;
    start = errors;
    pause = 1'b1;
    for (i = 0; i < 5; i++) begin
      send_tracked(random_byte(), 1'b0);
    end
    send_tracked(`LINE_TERM, 1'b0);
    repeat (10) @(negedge clk);
    expect_no_line("paused short line");
    check_flag("overflow with 6 bytes held", overflow, 1'b0);
    pause = 1'b0;
    expect_line("short line after pause");

    // Bytes past the FIFO depth are dropped while paused
    pause = 1'b1;
    for (i = 0; i < 12; i++) begin
      b = random_byte();
      if (i < `UART_FIFO_DEPTH) begin
        send_tracked(b, 1'b0);
      end else begin
        send_byte(b, 1'b0);
      end
    end
    check_flag("overflow after 12 bytes", overflow, 1'b1);
    pause = 1'b0;
    repeat (20) @(negedge clk);
    expect_no_line("drain of 8 bytes without LF");
    send_tracked(`LINE_TERM, 1'b0);
    expect_line("line of 8 held bytes");
    report_test("back-pressure", start);
  endtask

  initial begin
    seed_dummy   = $urandom(32'h26fd_ae27);
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    model_len    = 0;
    model_csum   = '0;
    model_err    = 1'b0;
    serial_in    = 1'b1;
    pause        = 1'b0;
    reset        = 1'b1;
    repeat (8) @(negedge clk);
    reset = 1'b0;

    test_reset_state();
    test_clean_lines();
    test_framing_error();
    test_glitch();
    test_overlong();
    test_pause();

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+include
src/uart_pkg.sv
src/line_pkg.sv
src/uart_rx.sv
src/rx_fifo.sv
src/line_assembler.sv
src/uart_line_top.sv
bench/uart_line_tb.sv

//--- Bender.yml
package:
  name: uart_line

sources:
  - include_dirs:
      - include
    files:
      - src/uart_pkg.sv
      - src/line_pkg.sv
      - src/uart_rx.sv
      - src/rx_fifo.sv
      - src/line_assembler.sv
      - src/uart_line_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/uart_line_tb.sv
